//--- aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

`define AES_ROUNDS     10   // cipher rounds for a 128-bit key.
`define AES_BLOCK_BITS 128  // one state block.
`define AES_KEY_BITS   128  // cipher key and round keys.

// wide enough to hold AES_ROUNDS.
`define AES_ROUND_BITS 4

`endif

//--- aesPkg.sv
`include "aes_cfg.svh"

package aesPkg;

    // byte 0 is the leftmost byte, column c holds bytes 4c to 4c+3.
    typedef logic [0:`AES_BLOCK_BITS/8-1][7:0] aesState_t;
    typedef logic [0:`AES_KEY_BITS/8-1][7:0] aesKey_t;

    typedef struct packed {
        aesKey_t   key;        // cipher key.
        aesState_t plainText;  // block to encrypt.
    } aesReq_t;

    typedef struct packed {
        aesState_t cipherText;
    } aesResp_t;

    typedef enum logic [1:0] {
        phIdle,     // waiting for req.
        phBusy,     // one round per clock.
        phDone,     // raises ack.
        phRelease   // holds ack until req drops.
    } aesPhase_t;

    // multiply by x in GF(2^8), reduced by the AES polynomial.
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- sBox.sv
`timescale 1ns/1ns

module sBox
(
    input  logic [7:0] inByte,
    output logic [7:0] outByte
);

    logic [7:0] inverse;

    // shift-and-add product in GF(2^8).
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] term;
        acc = 8'h00;
        term = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ term;
            term = aesPkg::xtime(term);
        end
        return acc;
    endfunction

    // x^254 equals x^-1 for nonzero x, and 0 stays 0.
    // collects x^2 * x^4 * ... * x^128.
    function automatic logic [7:0] gfInverse(input logic [7:0] x);
        logic [7:0] square;
        logic [7:0] acc;
        square = x;
        acc = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            square = gfMul(square, square);  // x^(2^i).
            acc = gfMul(acc, square);
        end
        return acc;
    endfunction

    assign inverse = gfInverse(inByte);

    // affine transform, b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63h.
    assign outByte = inverse
                   ^ {inverse[6:0], inverse[7]}
                   ^ {inverse[5:0], inverse[7:6]}
                   ^ {inverse[4:0], inverse[7:5]}
                   ^ {inverse[3:0], inverse[7:4]}
                   ^ 8'h63;

endmodule

//--- mixColumns.sv
`timescale 1ns/1ns

module mixColumns
(
    input  aesPkg::aesState_t inState,
    output aesPkg::aesState_t outState
);

    // each output byte is 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3],
    // with 3*a written as xtime(a) ^ a.
    always_comb
    begin
        logic [0:3][7:0] col;
        logic [0:3][7:0] dbl;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                col[r] = inState[4*c + r];
                dbl[r] = aesPkg::xtime(col[r]);  // 2*a.
            end
            for (int r = 0; r < 4; r++)
            begin
                outState[4*c + r] = dbl[r]
                                  ^ dbl[(r + 1) % 4]
                                  ^ col[(r + 1) % 4]
                                  ^ col[(r + 2) % 4]
                                  ^ col[(r + 3) % 4];
            end
        end
    end

endmodule

//--- roundDatapath.sv
`timescale 1ns/1ns

module roundDatapath
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              load,
    input  logic              step,
    input  logic              finalRound,
    input  aesPkg::aesState_t plainText,
    input  aesPkg::aesKey_t   roundKey,
    input  aesPkg::aesKey_t   cipherKey,
    output aesPkg::aesState_t state
);

    aesPkg::aesState_t subState;
    aesPkg::aesState_t shiftState;
    aesPkg::aesState_t mixState;
    aesPkg::aesState_t roundOut;

    // SubBytes, one S-box per byte.
    for (genvar i = 0; i < 16; i++)
    begin : gSub
        sBox sBox_i
        (
            .inByte  (state[i]),
            .outByte (subState[i])
        );
    end

    // row r rotates left by r columns.
    always_comb
    begin
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                shiftState[4*c + r] = subState[4*((c + r) % 4) + r];
    end

    mixColumns mixColumns_i
    (
        .inState  (shiftState),
        .outState (mixState)
    );

    assign roundOut = (finalRound ? shiftState : mixState) ^ roundKey;  // last round skips mixing.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= '0;
        else if (load)
            state <= plainText ^ cipherKey;  // initial AddRoundKey.
        else if (step)
            state <= roundOut;
    end

    // control must never start a block and run a round in one cycle.
    loadStepExclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(load && step));

endmodule

//--- keyExpand.sv
`timescale 1ns/1ns

module keyExpand
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            load,
    input  logic            step,
    input  aesPkg::aesKey_t cipherKey,
    output aesPkg::aesKey_t roundKey
);

    aesPkg::aesKey_t keyReg;
    aesPkg::aesKey_t nextKey;
    logic [7:0]      rcon;
    logic [0:3][7:0] subWord;
    logic [0:3][7:0] keyTemp;

    // SubWord(RotWord(w3)), rotated order is bytes 13, 14, 15, 12.
    for (genvar i = 0; i < 4; i++)
    begin : gSubWord
        sBox sBox_i
        (
            .inByte  (keyReg[12 + (i + 1) % 4]),
            .outByte (subWord[i])
        );
    end

    assign keyTemp = {subWord[0] ^ rcon, subWord[1], subWord[2], subWord[3]};

    // each word chains off the one before it.
    always_comb
    begin
        for (int b = 0; b < 4; b++)
            nextKey[b] = keyReg[b] ^ keyTemp[b];
        for (int w = 1; w < 4; w++)
            for (int b = 0; b < 4; b++)
                nextKey[4*w + b] = keyReg[4*w + b] ^ nextKey[4*(w - 1) + b];
    end

    assign roundKey = nextKey;  // key for the round that steps next.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            keyReg <= '0;
            rcon <= 8'h00;
        end
        else if (load)
        begin
            keyReg <= cipherKey;
            rcon <= 8'h01;  // restarts for every block.
        end
        else if (step)
        begin
            keyReg <= nextKey;
            rcon <= aesPkg::xtime(rcon);
        end
    end

endmodule

//--- roundCounter.sv
`timescale 1ns/1ns

`include "aes_cfg.svh"

module roundCounter
(
    input  logic clk,
    input  logic resetn,
    input  logic load,
    input  logic step,
    output logic lastRound,
    output logic finalRound
);

    localparam logic [`AES_ROUND_BITS-1:0] oneRound = 1;
    localparam logic [`AES_ROUND_BITS-1:0] lastIndex = `AES_ROUNDS;

    logic [`AES_ROUND_BITS-1:0] count;

    assign finalRound = (count == lastIndex);  // round without MixColumns.
    assign lastRound = step && finalRound;      // this step ends the cipher.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            count <= '0;
        else if (load)
            count <= oneRound;
        else if (step)
            count <= finalRound ? '0 : count + oneRound;  // back to 0 once done.
    end

    // no round runs past the last one before the next load.
    stepAfterLoad: assert property (@(posedge clk) disable iff (!resetn)
        step |-> count != '0);

endmodule

//--- aesControl.sv
`timescale 1ns/1ns

module aesControl
(
    input  logic clk,
    input  logic resetn,
    input  logic req,
    input  logic lastRound,
    output logic load,
    output logic step,
    output logic ack
);

    aesPkg::aesPhase_t phase;

    assign load = (phase == aesPkg::phIdle) && req;  // takes key and plaintext.
    assign step = (phase == aesPkg::phBusy);         // one round per cycle.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            phase <= aesPkg::phIdle;
            ack <= 1'b0;
        end
        else
        begin
            case (phase)
                aesPkg::phIdle:
                    if (req)
                        phase <= aesPkg::phBusy;
                aesPkg::phBusy:
                    if (lastRound)
                        phase <= aesPkg::phDone;
                aesPkg::phDone:
                begin
                    ack <= 1'b1;  // ciphertext is in the state register.
                    phase <= aesPkg::phRelease;
                end
                aesPkg::phRelease:
                    if (!req)
                    begin
                        ack <= 1'b0;
                        phase <= aesPkg::phIdle;
                    end
                default:
                    phase <= aesPkg::phIdle;
            endcase
        end
    end

    // ack only answers a request that was still held.
    ackAfterReq: assert property (@(posedge clk) disable iff (!resetn)
        $rose(ack) |-> $past(req));

    // a requester holds req until ack answers it.
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!resetn)
        $fell(req) |-> ack);

endmodule

//--- aesTop.sv
`timescale 1ns/1ns

module aesTop
(
    input  logic             clk,
    input  logic             resetn,
    input  logic             req,
    input  aesPkg::aesReq_t  reqData,
    output logic             ack,
    output aesPkg::aesResp_t respData
);

    logic              load;
    logic              step;
    logic              lastRound;
    logic              finalRound;
    aesPkg::aesKey_t   roundKey;
    aesPkg::aesState_t state;

    aesControl aesControl_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .lastRound (lastRound),
        .load      (load),
        .step      (step),
        .ack       (ack)
    );

    roundCounter roundCounter_i
    (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .step       (step),
        .lastRound  (lastRound),
        .finalRound (finalRound)
    );

    keyExpand keyExpand_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .load      (load),
        .step      (step),
        .cipherKey (reqData.key),
        .roundKey  (roundKey)
    );

    roundDatapath roundDatapath_i
    (
        .clk        (clk),
        .resetn     (resetn),
        .load       (load),
        .step       (step),
        .finalRound (finalRound),
        .plainText  (reqData.plainText),
        .roundKey   (roundKey),
        .cipherKey  (reqData.key),
        .state      (state)
    );

    assign respData.cipherText = state;  // stable from ack until the next load.

endmodule

//--- tbAes.sv
`timescale 1ns/1ns

module tbAes;

    localparam int numTests = 4;
    localparam int ackLatency = 11;  // edges from sampling req to ack.
    localparam int cycleLimit = numTests * 20 + 50;

    // C.1, appendix B, all zero, then C.1 again after a different key.
    localparam logic [127:0] keyTable [numTests] = '{
        128'h000102030405060708090a0b0c0d0e0f,
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h00000000000000000000000000000000,
        128'h000102030405060708090a0b0c0d0e0f
    };
    localparam logic [127:0] plainTable [numTests] = '{
        128'h00112233445566778899aabbccddeeff,
        128'h3243f6a8885a308d313198a2e0370734,
        128'h00000000000000000000000000000000,
        128'h00112233445566778899aabbccddeeff
    };
    localparam logic [127:0] cipherTable [numTests] = '{
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
        128'h69c4e0d86a7b0430d8cdb78070b4c55a
    };

    logic             clk;
    logic             resetn;
    logic             req;
    aesPkg::aesReq_t  reqData;
    logic             ack;
    aesPkg::aesResp_t respData;

    int seed = 32'he931_5498;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    aesTop aesTop_i
    (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .reqData  (reqData),
        .ack      (ack),
        .respData (respData)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // stops a hung handshake.
    initial
    begin
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, handshake never completed", cycleCount);
        $display("Simulation failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // one four-phase transfer, starting on a falling edge with ack low.
    task automatic runTransaction(input int index);
        int cycles;
        int hold;
        int gap;
        reqData.key = keyTable[index];
        reqData.plainText = plainTable[index];
        req = 1'b1;
        cycles = -1;  // first falling edge comes after the sampling edge.
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!ack && cycles < 2 * ackLatency);
        if (!ack)
        begin
            errorCount++;
            $display("ack never rose for test %0d", index);
        end
        checkValue("ack latency", 128'(cycles), 128'(ackLatency));
        checkValue("respData", respData.cipherText, cipherTable[index]);
        hold = $random(seed) & 3;  // extra time with req still high.
        repeat (hold)
        begin
            @(negedge clk);
            checkValue("ack", 128'(ack), 128'(1));
            checkValue("respData held", respData.cipherText, cipherTable[index]);
        end
        req = 1'b0;
        @(negedge clk);
        checkValue("ack", 128'(ack), 128'(0));  // falls on first edge with req low.
        gap = $random(seed) & 3;
        repeat (gap)
        begin
            @(negedge clk);
            checkValue("ack", 128'(ack), 128'(0));
        end
        $display("test %0d done, ciphertext %h, latency %0d, %0d errors so far",
                 index, respData.cipherText, cycles, errorCount);
    endtask

    initial
    begin
        resetn = 1'b0;
        req = 1'b0;
        reqData = '0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        // idle core must keep ack low.
        repeat (5)
        begin
            @(negedge clk);
            checkValue("ack", 128'(ack), 128'(0));
        end
        $display("test idle done, %0d errors so far", errorCount);
        for (int i = 0; i < numTests; i++)
            runTransaction(i);
        $display("%0d tests, %0d checks, %0d errors", numTests + 1, checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
aesPkg.sv
sBox.sv
mixColumns.sv
roundDatapath.sv
keyExpand.sv
roundCounter.sv
aesControl.sv
aesTop.sv
tbAes.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbAes
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log
PASSMSG   = Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
